// File: hw/fp32_real.svh
// --------------------------------------------------------------------
// FP32 <-> real conversion for behavioral arithmetic
// power-of-two helper, decode by fp_class_e, round-half-up on encode
// --------------------------------------------------------------------
`ifndef FP32_REAL_SVH
`define FP32_REAL_SVH

// 2**e by repeated multiply or divide, exact for any int exponent
function automatic real pow2_real(input int e);
  real v;
  v = 1.0;
  if (e >= 0) begin
    for (int i = 0; i < e; i++) begin
      v = v * 2.0;
    end
  end else begin
    for (int i = 0; i < -e; i++) begin
      v = v / 2.0;
    end
  end
  return v;
endfunction

// decode one word, inf reads as a large number and nan as zero
function automatic real fp32_to_real(input fp32_t f);
  fp_class_e cls;
  real       mag;
  if (f.exponent == 8'd0) begin
    cls = (f.mantissa == '0) ? FP_ZERO : FP_SUBNORMAL;
  end else if (f.exponent == 8'hff) begin
    cls = FP_SPECIAL;
  end else begin
    cls = FP_NORMAL;
  end
  case (cls)
    FP_ZERO:      mag = 0.0;
    // no hidden one, fixed exponent of 1 - bias
    FP_SUBNORMAL: mag = (real'(f.mantissa) / FP_MANT_ONE) * pow2_real(1 - FP_BIAS);
    FP_NORMAL:    mag = (1.0 + real'(f.mantissa) / FP_MANT_ONE)
                        * pow2_real(int'(f.exponent) - FP_BIAS);
    default:      mag = (f.mantissa == '0) ? 1.0e30 : 0.0;
  endcase
  return f.sign ? -mag : mag;
endfunction

// encode, values below the normal range flush to zero
function automatic fp32_t real_to_fp32(input real r);
  fp32_t       res;
  real         mag;
  int          e;
  int unsigned frac_i;
  res = '0;
  mag = (r < 0.0) ? -r : r;
  if (mag == 0.0) begin
    return res;
  end
  // bring mantissa into [1, 2)
  e = 0;
  while (mag >= 2.0) begin
    mag = mag / 2.0;
    e++;
  end
  while (mag < 1.0) begin
    mag = mag * 2.0;
    e--;
  end
  // round half up, carry out bumps the exponent
  frac_i = $rtoi((mag - 1.0) * FP_MANT_ONE + 0.5);
  if (frac_i >= (32'd1 << FP_MANT_W)) begin
    frac_i = 0;
    e++;
  end
  if (e + FP_BIAS < 1) begin
    return res;
  end
  res.sign     = (r < 0.0);
  res.exponent = 8'(e + FP_BIAS);
  res.mantissa = frac_i[FP_MANT_W-1:0];
  return res;
endfunction

`endif

// File: hw/attn_pkg.sv
// --------------------------------------------------------------------
// attention output package
// sizes, FP32 word type, decode class enum, bundle structs
// and the FP32 <-> real helpers pulled in from fp32_real.svh
// --------------------------------------------------------------------
package attn_pkg;

  // --------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------

  // tokens per bundle
  localparam int TOKENS = 4;
  // components per value vector
  localparam int DIM = 4;

  // fp32 field constants
  localparam int  FP_BIAS     = 127;
  localparam int  FP_MANT_W   = 23;
  // 2**23, weight of the mantissa lsb inverted
  localparam real FP_MANT_ONE = 8388608.0;

  // --------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------

  // single precision word, msb first
  typedef struct packed {
    logic                 sign;
    logic [7:0]           exponent;
    logic [FP_MANT_W-1:0] mantissa;
  } fp32_t;

  // decode path select for fp32_to_real
  typedef enum logic [1:0] {
    FP_ZERO,
    FP_SUBNORMAL,
    FP_NORMAL,
    FP_SPECIAL
  } fp_class_e;

  // raw scores plus value vectors, values token-major
  typedef struct packed {
    fp32_t [TOKENS-1:0]          scores;
    fp32_t [TOKENS-1:0][DIM-1:0] values;
  } score_bundle_t;

  // normalized weights, same value vectors
  typedef struct packed {
    fp32_t [TOKENS-1:0]          weights;
    fp32_t [TOKENS-1:0][DIM-1:0] values;
  } weight_bundle_t;

  // attention output vector
  typedef struct packed {
    fp32_t [DIM-1:0] elem;
  } attn_vec_t;

  // --------------------------------------------------------------------
  // conversion functions
  // --------------------------------------------------------------------
  `include "fp32_real.svh"

endpackage

// File: hw/score_normalizer.sv
// --------------------------------------------------------------------
// score normalizer, first elastic stage of the attention output
// divides each raw score by the score sum when a bundle is accepted
// --------------------------------------------------------------------
module score_normalizer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  attn_pkg::score_bundle_t  in_bundle_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output attn_pkg::weight_bundle_t out_bundle_o
);
  import attn_pkg::*;

  // held item
  logic           valid_q;
  weight_bundle_t bundle_q;
  // accepting edge
  logic           accept;
  // sign bit per incoming score
  logic [TOKENS-1:0] score_sign;

  // w[t] = s[t] / sum(s), all zero on zero sum
  function automatic weight_bundle_t normalize(input score_bundle_t b);
    weight_bundle_t res;
    real            s [TOKENS];
    real            sum;
    res.values = b.values;
    sum = 0.0;
    for (int t = 0; t < TOKENS; t++) begin
      s[t] = fp32_to_real(b.scores[t]);
      sum  = sum + s[t];
    end
    for (int t = 0; t < TOKENS; t++) begin
      res.weights[t] = (sum == 0.0) ? fp32_t'('0) : real_to_fp32(s[t] / sum);
    end
    return res;
  endfunction

  // --------------------------------------------------------------------
  // handshake
  // --------------------------------------------------------------------

  // free slot or slot drains this edge
  assign in_ready_o   = !valid_q || out_ready_i;
  assign accept       = in_valid_i && in_ready_o;
  assign out_valid_o  = valid_q;
  assign out_bundle_o = bundle_q;

  always_comb begin
    for (int t = 0; t < TOKENS; t++) begin
      score_sign[t] = in_bundle_i.scores[t].sign;
    end
  end

  // compute on accept, drop valid on drain only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      bundle_q <= '0;
    end else if (accept) begin
      valid_q  <= 1'b1;
      bundle_q <= normalize(in_bundle_i);
    end else if (valid_q && out_ready_i) begin
      valid_q  <= 1'b0;
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  // weights held while the elastic stage stalls us
  a_stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(out_bundle_o));

  // scores are raw non-negative values
  a_scores_nonneg: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> score_sign == '0);

endmodule

// File: hw/attn_elastic_stage.sv
// --------------------------------------------------------------------
// one-deep valid/ready buffer for a weighted bundle
// decouples the normalizer from a stalled weighted-sum unit
// --------------------------------------------------------------------
module attn_elastic_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  attn_pkg::weight_bundle_t in_bundle_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output attn_pkg::weight_bundle_t out_bundle_o
);
  import attn_pkg::*;

  logic           valid_q;
  weight_bundle_t bundle_q;
  logic           accept;

  // ready when empty or draining
  assign in_ready_o   = !valid_q || out_ready_i;
  assign accept       = in_valid_i && in_ready_o;
  assign out_valid_o  = valid_q;
  assign out_bundle_o = bundle_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      bundle_q <= '0;
    end else if (accept) begin
      // load replaces a draining item in the same edge
      valid_q  <= 1'b1;
      bundle_q <= in_bundle_i;
    end else if (valid_q && out_ready_i) begin
      valid_q  <= 1'b0;
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  // an item only leaves through a transfer
  a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o);

  // held bundle unchanged under stall
  a_stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(out_bundle_o));

endmodule

// File: hw/attn_weighted_sum.sv
// --------------------------------------------------------------------
// weighted-sum unit, last elastic stage of the attention output
// out[d] = sum over t of w[t] * v[t][d], computed on accept
// --------------------------------------------------------------------
module attn_weighted_sum (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  attn_pkg::weight_bundle_t in_bundle_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output attn_pkg::attn_vec_t      out_vec_o
);
  import attn_pkg::*;

  // --------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------

  logic      valid_q;
  attn_vec_t vec_q;
  logic      accept;

  // --------------------------------------------------------------------
  // arithmetic
  // --------------------------------------------------------------------

  // one dot product per component, tokens summed in order
  function automatic attn_vec_t weigh(input weight_bundle_t b);
    attn_vec_t res;
    real       acc;
    real       w;
    real       v;
    for (int d = 0; d < DIM; d++) begin
      acc = 0.0;
      for (int t = 0; t < TOKENS; t++) begin
        w   = fp32_to_real(b.weights[t]);
        v   = fp32_to_real(b.values[t][d]);
        acc = acc + w * v;
      end
      // single rounding per component
      res.elem[d] = real_to_fp32(acc);
    end
    return res;
  endfunction

  // --------------------------------------------------------------------
  // handshake
  // --------------------------------------------------------------------

  // empty or the sink takes the current vector
  assign in_ready_o  = !valid_q || out_ready_i;
  assign accept      = in_valid_i && in_ready_o;
  assign out_valid_o = valid_q;
  assign out_vec_o   = vec_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      vec_q   <= '0;
    end else if (accept) begin
      valid_q <= 1'b1;
      vec_q   <= weigh(in_bundle_i);
    end else if (valid_q && out_ready_i) begin
      // delivered, nothing new behind it
      valid_q <= 1'b0;
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  // result held while the sink stalls
  a_stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(out_vec_o));

endmodule

// File: hw/attn_output_unit.sv
// --------------------------------------------------------------------
// attention output top level
// normalizer -> elastic stage -> weighted-sum unit, three cycles deep
// --------------------------------------------------------------------
module attn_output_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  attn_pkg::score_bundle_t in_bundle_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output attn_pkg::attn_vec_t     out_vec_o
);
  import attn_pkg::*;

  // normalizer to elastic stage
  logic           norm_valid;
  logic           norm_ready;
  weight_bundle_t norm_bundle;
  // elastic stage to weighted-sum unit
  logic           buf_valid;
  logic           buf_ready;
  weight_bundle_t buf_bundle;

  score_normalizer score_normalizer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_bundle_i  (in_bundle_i),
    .out_valid_o  (norm_valid),
    .out_ready_i  (norm_ready),
    .out_bundle_o (norm_bundle)
  );

  // spare slot so the normalizer keeps accepting during a sink stall
  attn_elastic_stage attn_elastic_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (norm_valid),
    .in_ready_o   (norm_ready),
    .in_bundle_i  (norm_bundle),
    .out_valid_o  (buf_valid),
    .out_ready_i  (buf_ready),
    .out_bundle_o (buf_bundle)
  );

  attn_weighted_sum attn_weighted_sum_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (buf_valid),
    .in_ready_o  (buf_ready),
    .in_bundle_i (buf_bundle),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_vec_o   (out_vec_o)
  );

endmodule

// File: bench/attn_output_tb.sv
// --------------------------------------------------------------------
// testbench for the attention output unit
// file-driven bundles, stall, random and full-rate output phases
// --------------------------------------------------------------------
module attn_output_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import attn_pkg::*;

  localparam string       STIM_FILE    = "bench/attn_stimulus.txt";
  localparam int          WORDS        = 24;
  // 8 hex digits plus a separator per word
  localparam int          ROW_CHARS    = WORDS * 9 - 1;
  localparam int          TIMEOUT      = 200;
  localparam int          STALL_CYCLES = 20;
  // last lines run with the sink always ready
  localparam int          TPUT_LINES   = 6;
  localparam logic [31:0] LCG_SEED     = 32'hc007_4d32;

  logic          clk;
  logic          rst_n;
  logic          in_valid_i;
  logic          in_ready_o;
  score_bundle_t in_bundle_i;
  logic          out_valid_o;
  logic          out_ready_i;
  attn_vec_t     out_vec_o;

  score_bundle_t stim_in[$];
  attn_vec_t     stim_exp[$];
  int            n_lines;
  int            sent_cnt;
  int            recv_cnt;

  attn_output_unit attn_output_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_bundle_i (in_bundle_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_vec_o   (out_vec_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic read_stimulus();
    int            fd;
    string         line;
    logic [31:0]   w [WORDS];
    score_bundle_t b;
    attn_vec_t     e;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file bench/attn_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip column notes and blank lines
      if (line.len() < ROW_CHARS || line[0] == "#") begin
        continue;
      end
      for (int k = 0; k < WORDS; k++) begin
        if ($sscanf(line.substr(9 * k, 9 * k + 7), "%h", w[k]) != 1) begin
          abort_run("a stimulus line holds a word that is not hex");
        end
      end
      // scores, then values token-major, then expected output
      for (int t = 0; t < TOKENS; t++) begin
        b.scores[t] = w[t];
        for (int d = 0; d < DIM; d++) begin
          b.values[t][d] = w[TOKENS + t * DIM + d];
        end
      end
      for (int d = 0; d < DIM; d++) begin
        e.elem[d] = w[TOKENS + TOKENS * DIM + d];
      end
      stim_in.push_back(b);
      stim_exp.push_back(e);
    end
    $fclose(fd);
    n_lines = stim_in.size();
    if (n_lines <= TPUT_LINES) begin
      abort_run("the stimulus file holds too few bundles");
    end
  endtask

  // empty pipe, nothing out and input side open
  task automatic check_idle();
    assert (out_valid_o === 1'b0) else
      abort_run($sformatf("FAIL t=%0t out_valid_o expected 0 got %b", $time, out_valid_o));
    assert (in_ready_o === 1'b1) else
      abort_run($sformatf("FAIL t=%0t in_ready_o expected 1 got %b", $time, in_ready_o));
  endtask

  task automatic check_vec(input int idx);
    attn_vec_t e;
    e = stim_exp[idx];
    for (int d = 0; d < DIM; d++) begin
      assert (out_vec_o.elem[d] === e.elem[d]) else
        abort_run($sformatf("FAIL t=%0t out_vec_o.elem[%0d] line %0d expected %h got %h",
                            $time, d, idx, e.elem[d], out_vec_o.elem[d]));
    end
  endtask

  // --------------------------------------------------------------------
  // driver, one bundle per transfer, file order
  // --------------------------------------------------------------------

  task automatic drive_all();
    int wait_cyc;
    for (int i = 0; i < n_lines; i++) begin
      in_valid_i  <= 1'b1;
      in_bundle_i <= stim_in[i];
      wait_cyc = 0;
      do begin
        @(posedge clk);
        wait_cyc++;
        if (wait_cyc > TIMEOUT) begin
          abort_run("timed out waiting for in_ready_o to accept a bundle");
        end
      end while (!in_ready_o);
      sent_cnt++;
    end
    in_valid_i <= 1'b0;
  endtask

  // --------------------------------------------------------------------
  // monitor and sink ready
  // --------------------------------------------------------------------

  task automatic collect_all();
    int          cyc;
    int          idle;
    int          stall_acc;
    logic        held;
    attn_vec_t   held_vec;
    logic        tput;
    logic [31:0] lcg;
    cyc       = 0;
    idle      = 0;
    stall_acc = 0;
    held      = 1'b0;
    held_vec  = '0;
    tput      = 1'b0;
    lcg       = LCG_SEED;
    while (recv_cnt < n_lines) begin
      @(posedge clk);
      cyc++;
      idle++;
      if (idle > TIMEOUT) begin
        abort_run("timed out waiting for the next output vector");
      end
      // stalled vector must still be there, unchanged
      if (held) begin
        assert (out_valid_o === 1'b1) else
          abort_run($sformatf("FAIL t=%0t out_valid_o expected 1 got %b", $time, out_valid_o));
        assert (out_vec_o === held_vec) else
          abort_run($sformatf("FAIL t=%0t out_vec_o expected %h got %h",
                              $time, held_vec, out_vec_o));
      end
      if (cyc <= STALL_CYCLES && in_valid_i && in_ready_o) begin
        stall_acc++;
      end
      assert (stall_acc <= 3) else
        abort_run("more than three bundles were accepted while the output was stalled");
      // pipe full by the end of the stall
      if (cyc == STALL_CYCLES) begin
        assert (in_ready_o === 1'b0) else
          abort_run($sformatf("FAIL t=%0t in_ready_o expected 0 got %b", $time, in_ready_o));
      end
      // full rate, one vector every edge
      if (tput) begin
        assert (out_valid_o === 1'b1) else
          abort_run($sformatf("FAIL t=%0t out_valid_o expected 1 got %b", $time, out_valid_o));
      end
      if (out_valid_o && out_ready_i) begin
        // every vector out needs a bundle already taken in
        assert (recv_cnt < sent_cnt) else
          abort_run($sformatf("an output vector arrived with only %0d bundles sent",
                              sent_cnt));
        check_vec(recv_cnt);
        recv_cnt++;
        idle = 0;
      end
      held     = out_valid_o && !out_ready_i;
      held_vec = out_vec_o;
      // ready for the next edge
      if (cyc < STALL_CYCLES) begin
        out_ready_i <= 1'b0;
      end else if (recv_cnt >= n_lines - TPUT_LINES) begin
        out_ready_i <= 1'b1;
        tput = (recv_cnt < n_lines);
      end else begin
        lcg = lcg_next(lcg);
        out_ready_i <= lcg[31];
      end
    end
  endtask

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid_i  = 1'b0;
    in_bundle_i = '0;
    out_ready_i = 1'b0;
    sent_cnt    = 0;
    recv_cnt    = 0;
    read_stimulus();
    repeat (3) begin
      @(posedge clk);
      check_idle();
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_idle();
    fork
      drive_all();
      collect_all();
    join
    // no stray vector after the last one
    repeat (4) begin
      @(posedge clk);
      assert (out_valid_o === 1'b0) else
        abort_run($sformatf("FAIL t=%0t out_valid_o expected 0 got %b", $time, out_valid_o));
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: attn_output.f
+incdir+hw
hw/attn_pkg.sv
hw/score_normalizer.sv
hw/attn_elastic_stage.sv
hw/attn_weighted_sum.sv
hw/attn_output_unit.sv
bench/attn_output_tb.sv

// File: bench/attn_stimulus.txt
# columns: s0..s3 | v[t][d] for t=0..3, d=0..3, token-major | expected out[0..3]
# all hex fp32, 8 digits and one space per word; score sums are powers of two
3f800000 3f800000 3f800000 3f800000 3f800000 40000000 40400000 40800000 40800000 40400000 40000000 3f800000 3f800000 3f800000 3f800000 3f800000 40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000
40800000 00000000 00000000 00000000 3f000000 bf800000 3fc00000 40400000 41000000 41000000 41000000 41000000 3f800000 3f800000 3f800000 3f800000 40000000 40000000 40000000 40000000 3f000000 bf800000 3fc00000 40400000
00000000 00000000 00000000 00000000 3f800000 40000000 40400000 40800000 c0000000 3f000000 41000000 bf800000 40a00000 40c00000 40e00000 41000000 3e800000 3f400000 3fc00000 40200000 00000000 00000000 00000000 00000000
40000000 40000000 00000000 40800000 40800000 00000000 3f800000 40000000 00000000 40800000 3f800000 c0000000 41000000 41000000 41000000 41000000 3f800000 40000000 40400000 3f000000 3fc00000 40000000 40000000 3e800000
3f800000 40400000 00000000 00000000 40800000 41000000 c0800000 40000000 40800000 00000000 40800000 40000000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 40800000 40000000 40000000 40000000
3f000000 3f000000 3f000000 3f000000 3f800000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 3f800000 3e800000 3e800000 3e800000 3e800000
00000000 00000000 41000000 41000000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 40400000 c0000000 40a00000 3f000000 3f800000 40000000 bf800000 3fc00000 40000000 00000000 40000000 3f800000
3f800000 40000000 3f800000 40800000 41000000 00000000 00000000 3f800000 00000000 40800000 00000000 3f800000 00000000 00000000 41000000 3f800000 40000000 40000000 40000000 3f800000 40000000 40000000 40000000 3f800000
40400000 3f800000 40000000 40000000 3f800000 40000000 00000000 00000000 3f800000 00000000 41000000 00000000 3f800000 00000000 00000000 40800000 3f800000 c0000000 00000000 40800000 3f800000 3e800000 3f800000 40000000
00000000 00000000 00000000 40000000 3f800000 3f800000 3f800000 3f800000 40000000 40000000 40000000 40000000 40400000 40400000 40400000 40400000 40e00000 bfc00000 3f200000 40a00000 40e00000 bfc00000 3f200000 40a00000
40c00000 40000000 00000000 00000000 40800000 c0800000 40000000 3f800000 40800000 40800000 c0000000 40a00000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 40800000 c0000000 3f800000 40000000
3f800000 3f800000 40000000 00000000 40000000 40800000 00000000 3f800000 40000000 00000000 40800000 3f800000 3f800000 40000000 40400000 3f000000 41000000 41000000 41000000 41000000 3fc00000 40000000 40200000 3f400000
3e800000 3e800000 3f000000 3f800000 41000000 00000000 00000000 00000000 00000000 41000000 00000000 00000000 00000000 00000000 40800000 00000000 00000000 00000000 00000000 40000000 3f800000 3f800000 3f800000 3f800000
40a00000 3f800000 3f800000 3f800000 40000000 00000000 00000000 40000000 3f800000 41000000 00000000 00000000 3f800000 00000000 41000000 00000000 3f800000 00000000 00000000 c0000000 3fd00000 3f800000 3f800000 3f800000
